/* hdl/rvIsaPkg.sv */
package rvIsaPkg;

	typedef logic [31:0] word_t;
	typedef logic [4:0] regIndex_t;
	typedef logic [2:0] funct3_t;

	// RV32I major opcodes
	typedef enum logic [6:0] {
		LUI = 7'b0110111,
		AUIPC = 7'b0010111,
		JAL = 7'b1101111,
		JALR = 7'b1100111,
		BRANCH = 7'b1100011,
		LOAD = 7'b0000011,
		STORE = 7'b0100011,
		OPIMM = 7'b0010011,
		OP = 7'b0110011,
		MISCMEM = 7'b0001111,
		SYSTEM = 7'b1110011
	} opcode_t;

	typedef struct packed {
		regIndex_t rd;
		regIndex_t rs1;
		regIndex_t rs2;
		funct3_t funct3;
		logic alt;
		word_t imm;
		logic isLui;
		logic isAuipc;
		logic isJal;
		logic isJalr;
		logic isBranch;
		logic isLoad;
		logic isStore;
		logic isAluImm;
		logic isAlu;
		logic isFence;
		logic invalid;
	} decoded_t;

endpackage

/* hdl/rvCorePkg.sv */
package rvCorePkg;

	typedef enum logic [1:0] {
		HALT = 2'b00,
		FETCH = 2'b10,
		EXECUTE = 2'b11
	} coreState_t;

	// Bit 1 misaligned address or jump, bit 0 invalid instruction
	typedef logic [1:0] errorCode_t;
	typedef logic [15:0] mgmtAddr_t;

	localparam errorCode_t ErrorInvalid = 2'b01;
	localparam errorCode_t ErrorMisaligned = 2'b10;

	// Management address map
	localparam mgmtAddr_t MgmtAddrPc = 16'h0000;
	localparam mgmtAddr_t MgmtAddrInstruction = 16'h0010;
	localparam mgmtAddr_t MgmtAddrClearError = 16'h0020;
	localparam mgmtAddr_t MgmtAddrRegisters = 16'h4000;

	// Offsets inside the PC slot
	localparam logic [3:0] MgmtPcSet = 4'h0;
	localparam logic [3:0] MgmtPcJump = 4'h4;
	localparam logic [3:0] MgmtPcStep = 4'h8;

	typedef struct packed {
		logic writeEnable;
		logic [3:0] byteSelect;
		mgmtAddr_t address;
		rvIsaPkg::word_t writeData;
	} mgmtReq_t;

	typedef struct packed {
		rvIsaPkg::word_t address;
		logic [3:0] byteSelect;
		logic readEnable;
		logic writeEnable;
		rvIsaPkg::word_t writeData;
	} memReq_t;

endpackage

/* hdl/rvDecoder.sv */
`timescale 1ns/10ps

module rvDecoder (
	input rvIsaPkg::word_t instruction,
	output rvIsaPkg::decoded_t decoded
);
	import rvIsaPkg::*;

	opcode_t opcode;
	funct3_t funct3;
	logic [6:0] funct7;
	word_t immI;
	word_t immS;
	word_t immB;
	word_t immU;
	word_t immJ;
	logic isLui;
	logic isAuipc;
	logic isJal;
	logic isJalr;
	logic isBranch;
	logic isLoad;
	logic isStore;
	logic isAluImmNormal;
	logic isAluImmShift;
	logic isAlu;
	logic isFence;
	logic [9:0] classes;

	assign opcode = opcode_t'(instruction[6:0]);
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];

	assign immI = {{21{instruction[31]}}, instruction[30:20]};
	assign immS = {{21{instruction[31]}}, instruction[30:25], instruction[11:7]};
	assign immB = {{20{instruction[31]}}, instruction[7], instruction[30:25],
		instruction[11:8], 1'b0};
	assign immU = {instruction[31:12], 12'h000};
	assign immJ = {{12{instruction[31]}}, instruction[19:12], instruction[20],
		instruction[30:21], 1'b0};

	assign isLui = opcode == LUI;
	assign isAuipc = opcode == AUIPC;
	assign isJal = opcode == JAL;
	assign isJalr = opcode == JALR && funct3 == 3'b000;
	// 010 and 011 are not branch conditions
	assign isBranch = opcode == BRANCH && funct3[2:1] != 2'b01;
	assign isLoad = opcode == LOAD && funct3 != 3'b011 && funct3[2:1] != 2'b11;
	assign isStore = opcode == STORE && !funct3[2] && funct3[1:0] != 2'b11;
	assign isAluImmNormal = opcode == OPIMM && funct3 != 3'b001 && funct3 != 3'b101;
	assign isAluImmShift = opcode == OPIMM
		&& ((funct3 == 3'b001 && funct7 == 7'b0000000)
		|| (funct3 == 3'b101 && (funct7 == 7'b0000000 || funct7 == 7'b0100000)));
	assign isAlu = opcode == OP && (funct7 == 7'b0000000
		|| (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101)));
	assign isFence = opcode == MISCMEM && funct3 == 3'b000;

	assign classes = {isLui, isAuipc, isJal, isJalr, isBranch, isLoad, isStore,
		isAluImmNormal || isAluImmShift, isAlu, isFence};

	always_comb begin
		decoded.rd = instruction[11:7];
		decoded.rs1 = instruction[19:15];
		decoded.rs2 = instruction[24:20];
		decoded.funct3 = funct3;
		decoded.alt = instruction[30] && (isAlu || isAluImmShift);
		if (isLui || isAuipc) begin
			decoded.imm = immU;
		end else if (isJal) begin
			decoded.imm = immJ;
		end else if (isBranch) begin
			decoded.imm = immB;
		end else if (isStore) begin
			decoded.imm = immS;
		end else begin
			decoded.imm = immI;
		end
		decoded.isLui = isLui;
		decoded.isAuipc = isAuipc;
		decoded.isJal = isJal;
		decoded.isJalr = isJalr;
		decoded.isBranch = isBranch;
		decoded.isLoad = isLoad;
		decoded.isStore = isStore;
		decoded.isAluImm = isAluImmNormal || isAluImmShift;
		decoded.isAlu = isAlu;
		decoded.isFence = isFence;
		// Exactly one class must match, SYSTEM matches none
		decoded.invalid = !(classes != '0 && (classes & (classes - 10'd1)) == '0);
	end

endmodule

/* hdl/rvRegisterFile.sv */
`timescale 1ns/10ps

module rvRegisterFile #(
	parameter int RegCount = 32
) (
	input logic clk,
	input rvIsaPkg::regIndex_t rs1Index,
	input rvIsaPkg::regIndex_t rs2Index,
	input rvIsaPkg::regIndex_t mgmtIndex,
	output rvIsaPkg::word_t rs1Data,
	output rvIsaPkg::word_t rs2Data,
	output rvIsaPkg::word_t mgmtData,
	input logic writeEnable,
	input rvIsaPkg::regIndex_t writeIndex,
	input rvIsaPkg::word_t writeData
);
	import rvIsaPkg::*;

	word_t registers [RegCount];

	// x0 and indices past RegCount hold nothing
	function automatic logic isBacked(regIndex_t index);
		return index != '0 && int'(index) < RegCount;
	endfunction

	assign rs1Data = isBacked(rs1Index) ? registers[rs1Index] : '0;
	assign rs2Data = isBacked(rs2Index) ? registers[rs2Index] : '0;
	assign mgmtData = isBacked(mgmtIndex) ? registers[mgmtIndex] : '0;

	always_ff @(posedge clk) begin
		if (writeEnable && isBacked(writeIndex)) begin
			registers[writeIndex] <= writeData;
		end
	end

endmodule

/* hdl/rvAlu.sv */
`timescale 1ns/10ps

module rvAlu (
	input rvIsaPkg::decoded_t decoded,
	input rvIsaPkg::word_t pc,
	input rvIsaPkg::word_t rs1Data,
	input rvIsaPkg::word_t rs2Data,
	output rvIsaPkg::word_t result,
	output rvIsaPkg::word_t sum,
	output logic takeBranch
);
	import rvIsaPkg::*;

	word_t operandA;
	word_t operandB;
	logic [32:0] difference;
	logic equal;
	logic lessSigned;
	logic lessUnsigned;
	logic isLeftShift;
	word_t shiftInput;
	logic signed [32:0] shiftExtended;
	logic signed [32:0] shifted;
	word_t rightShift;

	function automatic word_t reverseBits(word_t value);
		word_t reversed;
		for (int i = 0; i < 32; i++) begin
			reversed[i] = value[31 - i];
		end
		return reversed;
	endfunction

	assign operandA = decoded.isAuipc ? pc : rs1Data;
	assign operandB = (decoded.isAuipc || decoded.isAluImm || decoded.isLoad || decoded.isStore)
		? decoded.imm : rs2Data;

	assign sum = operandA + operandB;

	// One subtractor serves SUB and every comparison
	assign difference = {1'b0, operandA} - {1'b0, operandB};
	assign equal = difference[31:0] == '0;
	assign lessUnsigned = difference[32];
	assign lessSigned = (operandA[31] ^ operandB[31]) ? operandA[31] : difference[32];

	// Left shifts reuse the right shifter on reversed bits
	assign isLeftShift = decoded.funct3 == 3'b001;
	assign shiftInput = isLeftShift ? reverseBits(operandA) : operandA;
	assign shiftExtended = {decoded.alt && !isLeftShift && shiftInput[31], shiftInput};
	assign shifted = shiftExtended >>> operandB[4:0];
	assign rightShift = shifted[31:0];

	always_comb begin
		case (decoded.funct3)
			3'b000: result = decoded.alt ? difference[31:0] : sum;
			3'b001: result = reverseBits(rightShift);
			3'b010: result = {31'b0, lessSigned};
			3'b011: result = {31'b0, lessUnsigned};
			3'b100: result = operandA ^ operandB;
			3'b101: result = rightShift;
			3'b110: result = operandA | operandB;
			default: result = operandA & operandB;
		endcase
	end

	always_comb begin
		takeBranch = 1'b0;
		if (decoded.isBranch) begin
			case (decoded.funct3)
				3'b000: takeBranch = equal;
				3'b001: takeBranch = !equal;
				3'b100: takeBranch = lessSigned;
				3'b101: takeBranch = !lessSigned;
				3'b110: takeBranch = lessUnsigned;
				3'b111: takeBranch = !lessUnsigned;
				default: takeBranch = 1'b0;
			endcase
		end
	end

endmodule

/* hdl/rvLoadStoreUnit.sv */
`timescale 1ns/10ps

module rvLoadStoreUnit (
	input rvCorePkg::coreState_t state,
	input rvIsaPkg::decoded_t decoded,
	input rvIsaPkg::word_t pc,
	input rvIsaPkg::word_t address,
	input rvIsaPkg::word_t storeValue,
	input rvIsaPkg::word_t memoryDataRead,
	output rvCorePkg::memReq_t memReq,
	output rvIsaPkg::word_t loadData,
	output logic misaligned
);
	import rvIsaPkg::*;
	import rvCorePkg::*;

	word_t target;
	logic [1:0] offset;
	logic [3:0] baseMask;
	logic [6:0] shiftedMask;
	logic active;
	word_t laneData;
	word_t placed;

	assign target = state == FETCH ? pc : address;
	assign offset = target[1:0];

	always_comb begin
		baseMask = 4'b0000;
		if (state == FETCH) begin
			baseMask = 4'b1111;
		end else if (state == EXECUTE && (decoded.isLoad || decoded.isStore)) begin
			case (decoded.funct3[1:0])
				2'b00: baseMask = 4'b0001;
				2'b01: baseMask = 4'b0011;
				2'b10: baseMask = 4'b1111;
				default: baseMask = 4'b0000;
			endcase
		end
	end

	// Lanes pushed past byte 3 cross a word boundary
	assign shiftedMask = {3'b000, baseMask} << offset;
	assign misaligned = |shiftedMask[6:4];
	assign active = |shiftedMask[3:0] && !misaligned;

	assign placed = storeValue << {offset, 3'b000};
	assign laneData = memoryDataRead >> {offset, 3'b000};

	always_comb begin
		memReq.address = active ? {target[31:2], 2'b00} : '0;
		memReq.byteSelect = active ? shiftedMask[3:0] : 4'b0000;
		memReq.readEnable = active && (state == FETCH || decoded.isLoad);
		memReq.writeEnable = active && state == EXECUTE && decoded.isStore;
		for (int lane = 0; lane < 4; lane++) begin
			memReq.writeData[8*lane +: 8] = (memReq.writeEnable && shiftedMask[lane])
				? placed[8*lane +: 8] : 8'h00;
		end
	end

	// funct3 bit 2 selects zero extension
	always_comb begin
		case (decoded.funct3)
			3'b000: loadData = {{24{laneData[7]}}, laneData[7:0]};
			3'b001: loadData = {{16{laneData[15]}}, laneData[15:0]};
			3'b100: loadData = {24'h000000, laneData[7:0]};
			3'b101: loadData = {16'h0000, laneData[15:0]};
			default: loadData = laneData;
		endcase
	end

endmodule

/* hdl/rvCore.sv */
`timescale 1ns/10ps

module rvCore #(
	parameter int RegCount = 32
) (
	input logic clk,
	input logic rst,
	input logic run,
	input rvCorePkg::mgmtReq_t mgmt,
	output rvIsaPkg::word_t mgmtReadData,
	output rvCorePkg::memReq_t memReq,
	input rvIsaPkg::word_t memoryDataRead,
	input logic memoryBusy,
	output rvCorePkg::coreState_t state,
	output rvCorePkg::errorCode_t errorCode
);
	import rvIsaPkg::*;
	import rvCorePkg::*;

	word_t pc;
	word_t instruction;
	decoded_t decoded;
	word_t rs1Data;
	word_t rs2Data;
	word_t mgmtRegData;
	word_t aluResult;
	word_t aluSum;
	logic takeBranch;
	word_t loadData;
	logic lsuMisaligned;
	logic selectPc;
	logic selectInstruction;
	logic selectClearError;
	logic selectRegister;
	logic writeValid;
	logic readValid;
	logic writePcSet;
	logic writePcJump;
	logic writePcStep;
	logic writeClearError;
	logic writeRegister;
	logic allowInstruction;
	word_t mgmtJumpTarget;
	word_t mgmtData;
	word_t link;
	logic isJump;
	word_t nextPcSum;
	word_t nextPc;
	logic jumpMisaligned;
	errorCode_t executeError;
	logic progress;
	logic coreWrite;
	word_t writeBackData;

	rvDecoder i_decoder (
		.instruction(instruction),
		.decoded(decoded)
	);

	rvRegisterFile #(
		.RegCount(RegCount)
	) i_registerFile (
		.clk(clk),
		.rs1Index(decoded.rs1),
		.rs2Index(decoded.rs2),
		.mgmtIndex(mgmt.address[6:2]),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.mgmtData(mgmtRegData),
		.writeEnable(coreWrite || writeRegister),
		.writeIndex(coreWrite ? decoded.rd : mgmt.address[6:2]),
		.writeData(coreWrite ? writeBackData : mgmt.writeData)
	);

	rvAlu i_alu (
		.decoded(decoded),
		.pc(pc),
		.rs1Data(rs1Data),
		.rs2Data(rs2Data),
		.result(aluResult),
		.sum(aluSum),
		.takeBranch(takeBranch)
	);

	rvLoadStoreUnit i_loadStoreUnit (
		.state(state),
		.decoded(decoded),
		.pc(pc),
		.address(aluSum),
		.storeValue(rs2Data),
		.memoryDataRead(memoryDataRead),
		.memReq(memReq),
		.loadData(loadData),
		.misaligned(lsuMisaligned)
	);

	// Management decode
	assign selectPc = mgmt.address[15:4] == MgmtAddrPc[15:4];
	assign selectInstruction = mgmt.address[15:4] == MgmtAddrInstruction[15:4];
	assign selectClearError = mgmt.address[15:4] == MgmtAddrClearError[15:4];
	assign selectRegister = mgmt.address[15:7] == MgmtAddrRegisters[15:7];

	assign writeValid = !run && mgmt.writeEnable && state == HALT;
	assign readValid = !run && !mgmt.writeEnable;
	assign writePcSet = writeValid && selectPc && mgmt.address[3:0] == MgmtPcSet;
	assign writePcJump = writeValid && selectPc && mgmt.address[3:0] == MgmtPcJump;
	assign writePcStep = writeValid && selectPc && mgmt.address[3:0] == MgmtPcStep;
	assign writeClearError = writeValid && selectClearError;
	assign writeRegister = writeValid && selectRegister;
	assign allowInstruction = run || writePcStep;
	assign mgmtJumpTarget = pc + mgmt.writeData;

	always_comb begin
		mgmtData = '0;
		if (readValid && selectPc) begin
			mgmtData = pc;
		end else if (readValid && selectInstruction) begin
			mgmtData = instruction;
		end else if (readValid && selectRegister) begin
			mgmtData = mgmtRegData;
		end
		for (int lane = 0; lane < 4; lane++) begin
			mgmtReadData[8*lane +: 8] = mgmt.byteSelect[lane] ? mgmtData[8*lane +: 8] : 8'h00;
		end
	end

	// Next PC, decoded.imm already holds the J, I or B immediate
	assign link = pc + 32'd4;
	assign isJump = decoded.isJal || decoded.isJalr || takeBranch;
	assign nextPcSum = (decoded.isJalr ? rs1Data : pc) + decoded.imm;
	assign nextPc = isJump ? {nextPcSum[31:1], 1'b0} : link;
	assign jumpMisaligned = isJump && nextPc[1];

	assign executeError = (lsuMisaligned || jumpMisaligned ? ErrorMisaligned : 2'b00)
		| (decoded.invalid ? ErrorInvalid : 2'b00);
	assign progress = (decoded.isLoad || decoded.isStore)
		? (memReq.readEnable || memReq.writeEnable) && !memoryBusy : 1'b1;

	assign coreWrite = state == EXECUTE && executeError == '0 && progress
		&& (decoded.isLui || decoded.isAuipc || decoded.isJal || decoded.isJalr
		|| decoded.isLoad || decoded.isAluImm || decoded.isAlu);
	assign writeBackData = decoded.isLui ? decoded.imm
		: decoded.isAuipc ? aluSum
		: (decoded.isJal || decoded.isJalr) ? link
		: decoded.isLoad ? loadData
		: aluResult;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= HALT;
			errorCode <= '0;
			pc <= '0;
			instruction <= '0;
		end else begin
			case (state)
				HALT: begin
					if (allowInstruction && errorCode == '0) begin
						state <= FETCH;
					end else if (writePcSet) begin
						pc <= {mgmt.writeData[31:1], 1'b0};
					end else if (writePcJump) begin
						pc <= {mgmtJumpTarget[31:1], 1'b0};
					end else if (writeClearError) begin
						errorCode <= '0;
					end
				end
				FETCH: begin
					if (lsuMisaligned) begin
						errorCode <= ErrorMisaligned;
						state <= HALT;
					end else if (memReq.readEnable && !memoryBusy) begin
						instruction <= memoryDataRead;
						state <= EXECUTE;
					end
				end
				EXECUTE: begin
					if (executeError != '0) begin
						errorCode <= executeError;
						state <= HALT;
					end else if (progress) begin
						pc <= nextPc;
						state <= run ? FETCH : HALT;
					end
				end
				default: begin
					state <= HALT;
				end
			endcase
		end
	end

endmodule

/* test/rvCore_asserts.sv */
`timescale 1ns/10ps

module rvCore_asserts (
	input logic clk,
	input logic rst,
	input rvCorePkg::memReq_t memReq,
	input logic memoryBusy,
	input rvCorePkg::coreState_t state,
	input rvCorePkg::errorCode_t errorCode
);
	import rvCorePkg::*;

	logic anyEnable;
	int failureCount = 0;

	assign anyEnable = memReq.readEnable || memReq.writeEnable;

	enablesExclusive: assert property (@(posedge clk) disable iff (rst)
		!(memReq.readEnable && memReq.writeEnable))
		else begin
			$error("Memory read and write enables are high together");
			failureCount++;
		end

	quietInHalt: assert property (@(posedge clk) disable iff (rst)
		state == HALT |-> !anyEnable)
		else begin
			$error("Memory enable raised while the core is in HALT");
			failureCount++;
		end

	// An error code pins the core in HALT
	haltOnError: assert property (@(posedge clk) disable iff (rst)
		(state == HALT && errorCode != '0) |=> state == HALT)
		else begin
			$error("Core left HALT with a pending error code");
			failureCount++;
		end

	stableWhileBusy: assert property (@(posedge clk) disable iff (rst)
		(memoryBusy && anyEnable) |=> $stable(memReq))
		else begin
			$error("Memory request changed while memoryBusy was high");
			failureCount++;
		end

endmodule

bind rvCore rvCore_asserts i_asserts (
	.clk(clk),
	.rst(rst),
	.memReq(memReq),
	.memoryBusy(memoryBusy),
	.state(state),
	.errorCode(errorCode)
);

/* test/rvMemoryModel.sv */
`timescale 1ns/10ps

module rvMemoryModel (
	input logic clk,
	input logic rst,
	input rvCorePkg::memReq_t memReq,
	output rvIsaPkg::word_t memoryDataRead,
	output logic memoryBusy
);
	import rvIsaPkg::*;
	import rvCorePkg::*;

	localparam word_t FillPattern = 32'ha5c3_1e70;

	typedef struct packed {
		word_t address;
		logic [7:0] data;
	} byteWrite_t;

	word_t contents [word_t];
	byteWrite_t writeLog [$];
	int seed;

	// Untouched words hold their own address XOR the fill pattern
	function automatic word_t readWord(word_t address);
		word_t aligned;
		aligned = {address[31:2], 2'b00};
		if (contents.exists(aligned)) begin
			return contents[aligned];
		end
		return aligned ^ FillPattern;
	endfunction

	task automatic writeWord(word_t address, word_t data);
		contents[{address[31:2], 2'b00}] = data;
	endtask

	assign memoryDataRead = memReq.readEnable ? readWord(memReq.address) : '0;

	initial begin
		seed = 32'h2f8d_9592;
		memoryBusy = 1'b0;
	end

	always @(posedge clk) begin : access
		word_t merged;
		if (rst) begin
			memoryBusy <= 1'b0;
		end else begin
			if (memReq.writeEnable && !memoryBusy) begin
				merged = readWord(memReq.address);
				for (int lane = 0; lane < 4; lane++) begin
					if (memReq.byteSelect[lane]) begin
						merged[8*lane +: 8] = memReq.writeData[8*lane +: 8];
						writeLog.push_back('{memReq.address + lane, memReq.writeData[8*lane +: 8]});
					end
				end
				contents[{memReq.address[31:2], 2'b00}] = merged;
			end
			// Roughly one cycle in four stalls
			memoryBusy <= ($random(seed) & 3) == 0;
		end
	end

endmodule

/* test/rvCoreTb.sv */
`timescale 1ns/10ps

module rvCoreTb;
	import rvIsaPkg::*;
	import rvCorePkg::*;

	localparam time ClockPeriod = 100ns;
	localparam word_t MemoryPattern = 32'ha5c3_1e70;
	localparam word_t RdMarker = 32'h5a5a_0033;
	localparam word_t CodeAddress = 32'h0000_0200;
	localparam int HaltLimit = 150;

	typedef struct packed {
		word_t instruction;
		word_t rs1Value;
		word_t rs2Value;
		word_t startPc;
		word_t expRd;
		word_t expNextPc;
		errorCode_t expError;
		logic [2:0] expWrites;
	} testRow_t;

	logic clk;
	logic rst;
	logic run;
	mgmtReq_t mgmt;
	word_t mgmtReadData;
	memReq_t memReq;
	word_t memoryDataRead;
	logic memoryBusy;
	coreState_t state;
	errorCode_t errorCode;
	testRow_t testTable [$];
	word_t shadow [word_t];
	logic tableReady;

	rvCore #(
		.RegCount(32)
	) i_dut (
		.clk(clk),
		.rst(rst),
		.run(run),
		.mgmt(mgmt),
		.mgmtReadData(mgmtReadData),
		.memReq(memReq),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy),
		.state(state),
		.errorCode(errorCode)
	);

	rvMemoryModel i_memory (
		.clk(clk),
		.rst(rst),
		.memReq(memReq),
		.memoryDataRead(memoryDataRead),
		.memoryBusy(memoryBusy)
	);

	initial begin
		clk = 1'b0;
		forever #(ClockPeriod / 2) clk = ~clk;
	end

	// Encoders use x1 and x2 as sources and x3 as destination
	function automatic word_t encR(logic [6:0] funct7, funct3_t funct3, logic [6:0] op);
		return {funct7, 5'd2, 5'd1, funct3, 5'd3, op};
	endfunction

	function automatic word_t encI(logic [11:0] imm, funct3_t funct3, logic [6:0] op);
		return {imm, 5'd1, funct3, 5'd3, op};
	endfunction

	function automatic word_t encS(logic [11:0] imm, funct3_t funct3);
		return {imm[11:5], 5'd2, 5'd1, funct3, imm[4:0], 7'b0100011};
	endfunction

	function automatic word_t encB(logic [12:0] imm, funct3_t funct3);
		return {imm[12], imm[10:5], 5'd2, 5'd1, funct3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t encU(logic [19:0] imm, logic [6:0] op);
		return {imm, 5'd3, op};
	endfunction

	function automatic word_t encJ(logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], 5'd3, 7'b1101111};
	endfunction

	function automatic word_t memoryWord(word_t address);
		word_t aligned;
		aligned = {address[31:2], 2'b00};
		if (shadow.exists(aligned)) begin
			return shadow[aligned];
		end
		return aligned ^ MemoryPattern;
	endfunction

	function automatic void storeBytes(word_t address, word_t value, int count);
		word_t merged;
		merged = memoryWord(address);
		for (int i = 0; i < count; i++) begin
			merged[8*(address[1:0] + i) +: 8] = value[8*i +: 8];
		end
		shadow[{address[31:2], 2'b00}] = merged;
	endfunction

	function automatic word_t loadRule(funct3_t funct3, word_t address);
		word_t lanes;
		lanes = memoryWord(address) >> (8 * address[1:0]);
		case (funct3)
			3'b000: return {{24{lanes[7]}}, lanes[7:0]};
			3'b001: return {{16{lanes[15]}}, lanes[15:0]};
			3'b100: return {24'h0, lanes[7:0]};
			3'b101: return {16'h0, lanes[15:0]};
			default: return lanes;
		endcase
	endfunction

	function automatic word_t aluRule(funct3_t funct3, logic alt, word_t a, word_t b);
		case (funct3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return {31'b0, $signed(a) < $signed(b)};
			3'b011: return {31'b0, a < b};
			3'b100: return a ^ b;
			3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	function automatic logic branchRule(funct3_t funct3, word_t a, word_t b);
		case (funct3)
			3'b000: return a == b;
			3'b001: return a != b;
			3'b100: return $signed(a) < $signed(b);
			3'b101: return $signed(a) >= $signed(b);
			3'b110: return a < b;
			default: return a >= b;
		endcase
	endfunction

	// Expected outcome of one instruction from the ISA rules
	function automatic testRow_t makeRow(word_t ins, word_t a, word_t b, word_t pc);
		testRow_t row;
		word_t immI;
		word_t immS;
		word_t immB;
		word_t immU;
		word_t immJ;
		word_t target;
		word_t address;
		int width;
		row.instruction = ins;
		row.rs1Value = a;
		row.rs2Value = b;
		row.startPc = pc;
		row.expRd = RdMarker;
		row.expNextPc = pc + 4;
		row.expError = '0;
		row.expWrites = '0;
		immI = {{20{ins[31]}}, ins[31:20]};
		immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
		immB = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
		immU = {ins[31:12], 12'h000};
		immJ = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
		width = 1 << ins[13:12];
		case (ins[6:0])
			7'b0110111: row.expRd = immU;
			7'b0010111: row.expRd = pc + immU;
			7'b1101111, 7'b1100111: begin
				target = ins[3] ? pc + immJ : (a + immI) & ~32'd1;
				if (target[1]) begin
					row.expError = 2'b10;
				end else begin
					row.expRd = pc + 4;
					row.expNextPc = target;
				end
			end
			7'b1100011: begin
				if (branchRule(ins[14:12], a, b)) begin
					row.expNextPc = pc + immB;
				end
			end
			7'b0000011: begin
				address = a + immI;
				if (address[1:0] + width > 4) begin
					row.expError = 2'b10;
				end else begin
					row.expRd = loadRule(ins[14:12], address);
				end
			end
			7'b0100011: begin
				address = a + immS;
				if (address[1:0] + width > 4) begin
					row.expError = 2'b10;
				end else begin
					storeBytes(address, b, width);
					row.expWrites = 3'(width);
				end
			end
			7'b0010011: row.expRd = aluRule(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
			7'b0110011: begin
				// SUB and SRA are the only users of funct7 0100000
				if (ins[31:25] == 7'h00 || (ins[31:25] == 7'h20
					&& (ins[14:12] == 3'b000 || ins[14:12] == 3'b101))) begin
					row.expRd = aluRule(ins[14:12], ins[30], a, b);
				end else begin
					row.expError = 2'b01;
				end
			end
			7'b0001111: row.expRd = RdMarker;
			default: row.expError = 2'b01;
		endcase
		if (row.expError != '0) begin
			row.expNextPc = pc;
		end
		return row;
	endfunction

	function automatic void addRow(word_t ins, word_t a, word_t b, word_t pc);
		testRow_t row;
		row = makeRow(ins, a, b, pc);
		testTable.push_back(row);
	endfunction

	task automatic buildTable();
		funct3_t conditions [6];
		word_t leftValues [3];
		word_t rightValues [3];
		conditions = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
		leftValues = '{32'd5, 32'hffff_fffd, 32'd7};
		rightValues = '{32'd5, 32'd7, 32'hffff_fffd};
		addRow(encR(7'h00, 3'b000, OP), 32'h1234_5678, 32'h0fed_cba9, CodeAddress);
		addRow(encR(7'h20, 3'b000, OP), 32'h0000_0005, 32'h0000_0007, CodeAddress);
		addRow(encR(7'h00, 3'b001, OP), 32'h8000_00f3, 32'h0000_0024, CodeAddress);
		addRow(encR(7'h00, 3'b010, OP), 32'hffff_fffd, 32'h0000_0007, CodeAddress);
		addRow(encR(7'h00, 3'b011, OP), 32'hffff_fffd, 32'h0000_0007, CodeAddress);
		addRow(encR(7'h00, 3'b100, OP), 32'hf0f0_1234, 32'h0ff0_4321, CodeAddress);
		addRow(encR(7'h00, 3'b101, OP), 32'h8000_00f3, 32'h0000_0008, CodeAddress);
		addRow(encR(7'h20, 3'b101, OP), 32'h8000_00f3, 32'h0000_0008, CodeAddress);
		addRow(encR(7'h00, 3'b110, OP), 32'hf0f0_1234, 32'h0ff0_4321, CodeAddress);
		addRow(encR(7'h00, 3'b111, OP), 32'hf0f0_1234, 32'h0ff0_4321, CodeAddress);
		addRow(encI(12'hffb, 3'b000, OPIMM), 32'h0000_0003, '0, CodeAddress);
		addRow(encI(12'h001, 3'b010, OPIMM), 32'hffff_fffd, '0, CodeAddress);
		addRow(encI(12'hfff, 3'b011, OPIMM), 32'h0000_0005, '0, CodeAddress);
		addRow(encI(12'h0f0, 3'b100, OPIMM), 32'h1234_5678, '0, CodeAddress);
		addRow(encI(12'h800, 3'b110, OPIMM), 32'h1234_5678, '0, CodeAddress);
		addRow(encI(12'h7ff, 3'b111, OPIMM), 32'h1234_5678, '0, CodeAddress);
		addRow(encI(12'h004, 3'b001, OPIMM), 32'h8000_00f3, '0, CodeAddress);
		addRow(encI(12'h008, 3'b101, OPIMM), 32'h8000_00f3, '0, CodeAddress);
		addRow(encI(12'h408, 3'b101, OPIMM), 32'h8000_00f3, '0, CodeAddress);
		addRow(encU(20'hdeadb, LUI), '0, '0, CodeAddress);
		addRow(encU(20'h00012, AUIPC), '0, '0, CodeAddress);
		addRow(encI(12'h0ff, 3'b000, MISCMEM), '0, '0, CodeAddress);
		for (int c = 0; c < 6; c++) begin
			for (int p = 0; p < 3; p++) begin
				addRow(encB(p == 1 ? 13'h1ff8 : 13'h0010, conditions[c]),
					leftValues[p], rightValues[p], CodeAddress);
			end
		end
		addRow(encJ(21'h000040), '0, '0, CodeAddress);
		addRow(encI(12'h004, 3'b000, JALR), 32'h0000_0201, '0, CodeAddress);
		addRow(encI(12'h000, 3'b000, JALR), 32'h0000_0301, '0, CodeAddress);
		for (int offset = 0; offset < 4; offset++) begin
			addRow(encI(12'(offset), 3'b000, LOAD), 32'h0000_1000, '0, CodeAddress);
		end
		addRow(encI(12'h003, 3'b100, LOAD), 32'h0000_1000, '0, CodeAddress);
		addRow(encI(12'h000, 3'b001, LOAD), 32'h0000_1000, '0, CodeAddress);
		addRow(encI(12'h001, 3'b001, LOAD), 32'h0000_1000, '0, CodeAddress);
		addRow(encI(12'h002, 3'b001, LOAD), 32'h0000_1000, '0, CodeAddress);
		addRow(encI(12'h002, 3'b101, LOAD), 32'h0000_1000, '0, CodeAddress);
		addRow(encI(12'h000, 3'b010, LOAD), 32'h0000_1000, '0, CodeAddress);
		addRow(encS(12'h001, 3'b000), 32'h0000_1100, 32'hc3b2_a190, CodeAddress);
		addRow(encS(12'h002, 3'b001), 32'h0000_1100, 32'hc3b2_a190, CodeAddress);
		addRow(encS(12'h000, 3'b010), 32'h0000_1104, 32'h7e6d_5c4b, CodeAddress);
		addRow(encI(12'h000, 3'b010, LOAD), 32'h0000_1100, '0, CodeAddress);
		addRow(encI(12'h000, 3'b010, LOAD), 32'h0000_1104, '0, CodeAddress);
		addRow(encI(12'h001, 3'b000, LOAD), 32'h0000_1100, '0, CodeAddress);
		// Faulting cases
		addRow(encR(7'h20, 3'b001, OP), 32'h0000_0001, 32'h0000_0002, CodeAddress);
		addRow(32'h0000_0073, '0, '0, CodeAddress);
		addRow(encJ(21'h000006), '0, '0, CodeAddress);
		addRow(encI(12'h001, 3'b000, JALR), 32'h0000_0201, '0, CodeAddress);
		addRow(encI(12'h002, 3'b010, LOAD), 32'h0000_1000, '0, CodeAddress);
		addRow(encI(12'h003, 3'b001, LOAD), 32'h0000_1000, '0, CodeAddress);
		addRow(encS(12'h003, 3'b001), 32'h0000_1100, 32'h1111_2222, CodeAddress);
	endtask

	function automatic mgmtAddr_t regAddr(regIndex_t index);
		return MgmtAddrRegisters | mgmtAddr_t'({index, 2'b00});
	endfunction

	function automatic mgmtAddr_t pcSlot(logic [3:0] offset);
		return {MgmtAddrPc[15:4], offset};
	endfunction

	task automatic check(string name, word_t actual, word_t expected);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s is %h, expected %h", $time, name, actual, expected);
			$display("FAIL: see errors above");
			$fatal(1);
		end
	endtask

	task automatic writeMgmt(mgmtAddr_t address, word_t data);
		@(posedge clk);
		mgmt <= '{writeEnable: 1'b1, byteSelect: 4'hf, address: address, writeData: data};
		@(posedge clk);
		mgmt <= '{writeEnable: 1'b0, byteSelect: 4'hf, address: address, writeData: '0};
	endtask

	task automatic readMgmt(mgmtAddr_t address, logic [3:0] byteSelect, output word_t data);
		@(posedge clk);
		mgmt <= '{writeEnable: 1'b0, byteSelect: byteSelect, address: address, writeData: '0};
		@(negedge clk);
		data = mgmtReadData;
	endtask

	task automatic waitHalt();
		int cycles;
		cycles = 0;
		@(negedge clk);
		while (state != HALT) begin
			cycles++;
			if (cycles > HaltLimit) begin
				$display("Core did not return to HALT within %0d cycles", HaltLimit);
				$display("FAIL: see errors above");
				$fatal(1);
			end
			@(negedge clk);
		end
	endtask

	task automatic checkManagement();
		word_t value;
		writeMgmt(regAddr(5'd0), 32'hffff_ffff);
		readMgmt(regAddr(5'd0), 4'hf, value);
		check("x0", value, 32'h0000_0000);
		writeMgmt(regAddr(5'd5), 32'hcafe_f00d);
		readMgmt(regAddr(5'd5), 4'b1010, value);
		check("x5 upper lanes", value, 32'hca00_f000);
		writeMgmt(pcSlot(MgmtPcSet), 32'h1234_5678);
		readMgmt(pcSlot(MgmtPcSet), 4'b0101, value);
		check("pc lanes 0 and 2", value, 32'h0034_0078);
		writeMgmt(pcSlot(MgmtPcJump), 32'hffff_fff0);
		readMgmt(pcSlot(MgmtPcSet), 4'hf, value);
		check("pc after jump", value, 32'h1234_5668);
	endtask

	task automatic applyRow(testRow_t row, int index);
		word_t value;
		int logStart;
		writeMgmt(regAddr(5'd1), row.rs1Value);
		writeMgmt(regAddr(5'd2), row.rs2Value);
		writeMgmt(regAddr(5'd3), RdMarker);
		i_memory.writeWord(row.startPc, row.instruction);
		writeMgmt(pcSlot(MgmtPcSet), row.startPc);
		logStart = i_memory.writeLog.size();
		writeMgmt(pcSlot(MgmtPcStep), '0);
		waitHalt();
		readMgmt(regAddr(5'd3), 4'hf, value);
		check($sformatf("row %0d rd", index), value, row.expRd);
		readMgmt(pcSlot(MgmtPcSet), 4'hf, value);
		check($sformatf("row %0d pc", index), value, row.expNextPc);
		readMgmt(MgmtAddrInstruction, 4'hf, value);
		check($sformatf("row %0d instruction", index), value, row.instruction);
		check($sformatf("row %0d errorCode", index), word_t'(errorCode), word_t'(row.expError));
		check($sformatf("row %0d bytes written", index),
			word_t'(i_memory.writeLog.size() - logStart), word_t'(row.expWrites));
		if (row.expError != '0) begin
			// Stepping is refused until the error is cleared
			writeMgmt(pcSlot(MgmtPcStep), '0);
			@(negedge clk);
			check($sformatf("row %0d state", index), word_t'(state), word_t'(HALT));
			readMgmt(pcSlot(MgmtPcSet), 4'hf, value);
			check($sformatf("row %0d pc held", index), value, row.startPc);
			writeMgmt(MgmtAddrClearError, '0);
			@(negedge clk);
			check($sformatf("row %0d errorCode cleared", index), word_t'(errorCode), '0);
		end
	endtask

	initial begin
		rst = 1'b1;
		run = 1'b0;
		mgmt = '0;
		tableReady = 1'b0;
		buildTable();
		tableReady = 1'b1;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		checkManagement();
		foreach (testTable[i]) begin
			applyRow(testTable[i], i);
		end
		if (i_dut.i_asserts.failureCount == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

	initial begin
		wait (tableReady);
		#(testTable.size() * 200 * ClockPeriod);
		$display("Watchdog expired before the tests finished");
		$display("FAIL: see errors above");
		$fatal(1);
	end

endmodule

/* src.f */
hdl/rvIsaPkg.sv
hdl/rvCorePkg.sv
hdl/rvDecoder.sv
hdl/rvRegisterFile.sv
hdl/rvAlu.sv
hdl/rvLoadStoreUnit.sv
hdl/rvCore.sv
test/rvCore_asserts.sv
test/rvMemoryModel.sv
test/rvCoreTb.sv

/* Bender.yml */
package:
  name: rvcore

sources:
  - files:
      - hdl/rvIsaPkg.sv
      - hdl/rvCorePkg.sv
      - hdl/rvDecoder.sv
      - hdl/rvRegisterFile.sv
      - hdl/rvAlu.sv
      - hdl/rvLoadStoreUnit.sv
      - hdl/rvCore.sv
  - target: test
    files:
      - test/rvCore_asserts.sv
      - test/rvMemoryModel.sv
      - test/rvCoreTb.sv
